// File: design/copy_vote_consts.svh
`ifndef COPY_VOTE_CONSTS_SVH
`define COPY_VOTE_CONSTS_SVH

// stream and buffer widths
`define COPY_VOTE_DATA_W 8
`define COPY_VOTE_ADDR_W 8 // 256 byte payload buffers

// redundancy
`define COPY_VOTE_N_COPIES 5
`define COPY_VOTE_N_PAIRS 10 // n*(n-1)/2

// frame layout
`define COPY_VOTE_ID_OFFSET 22 // byte carrying the copy number

`endif

// File: design/copy_vote_pkg.sv
`default_nettype none

`include "copy_vote_consts.svh"

package copy_vote_pkg;

	typedef logic [`COPY_VOTE_DATA_W-1:0] byte_t;
	typedef logic [`COPY_VOTE_ADDR_W-1:0] addr_t; // address or payload length
	typedef logic [2:0] copy_id_t; // 0 = none
	typedef logic [`COPY_VOTE_N_COPIES-1:0] copy_vec_t; // bit 0 = copy 1

	// pair order 12 13 14 15 23 24 25 34 35 45 starting at bit 0
	typedef logic [`COPY_VOTE_N_PAIRS-1:0] pair_vec_t;

	typedef logic [`COPY_VOTE_N_COPIES-1:0][`COPY_VOTE_ADDR_W-1:0] len_vec_t;
	typedef logic [`COPY_VOTE_N_COPIES-1:0][`COPY_VOTE_DATA_W-1:0] byte_vec_t;

	typedef enum logic [1:0] {
		idle,
		scan,
		decide,
		replay
	} vote_state_t;

endpackage

`default_nettype wire

// File: design/copy_receiver.sv
`timescale 1ns/100ps
`default_nettype none

`include "copy_vote_consts.svh"

module copy_receiver (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rx_en,
	input  copy_vote_pkg::byte_t      rx_data,
	input  logic                      busy,
	output copy_vote_pkg::copy_vec_t  wr_sel,
	output copy_vote_pkg::addr_t      wr_addr,
	output copy_vote_pkg::byte_t      wr_data,
	output copy_vote_pkg::len_vec_t   lens,
	output copy_vote_pkg::copy_vec_t  present,
	output logic                      round_done
);

	logic                    rx_en_q;
	copy_vote_pkg::byte_t    rx_data_q;
	logic [8:0]              byte_cnt;  // index of rx_data_q within the frame
	copy_vote_pkg::copy_id_t cur_id;    // copy of the frame in flight
	copy_vote_pkg::addr_t    pay_addr;  // next payload address
	logic [3:0]              id_nib;
	logic                    id_hit;
	logic                    id_ok;
	logic                    payload;
	logic                    frame_end;

	// ==================================================
	// frame decode
	// ==================================================
	assign id_nib    = rx_data_q[3:0];
	assign id_hit    = rx_en_q && (byte_cnt == 9'(`COPY_VOTE_ID_OFFSET)) && !busy;
	assign id_ok     = (id_nib >= 4'd1) && (id_nib <= 4'(`COPY_VOTE_N_COPIES));
	assign payload   = rx_en_q && (cur_id != '0)
		&& (byte_cnt > 9'(`COPY_VOTE_ID_OFFSET));
	assign frame_end = !rx_en_q && (byte_cnt != '0); // first idle cycle after a frame

	// input stage and write data
	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
		wr_data   <= rx_data_q;
		wr_addr   <= pay_addr;
	end

	// ==================================================
	// control state
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_en_q    <= 1'b0;
			byte_cnt   <= '0;
			cur_id     <= '0;
			pay_addr   <= '0;
			wr_sel     <= '0;
			lens       <= '0;
			present    <= '0;
			round_done <= 1'b0;
		end else begin
			rx_en_q    <= rx_en;
			wr_sel     <= '0;
			round_done <= 1'b0;

			if (!rx_en_q)
				byte_cnt <= '0;
			else if (byte_cnt != '1)
				byte_cnt <= byte_cnt + 9'd1; // saturates on oversized frames

			if (id_hit) begin
				pay_addr <= '0;
				cur_id   <= id_ok ? id_nib[2:0] : 3'd0; // bad id drops the frame
				if (id_nib == 4'd1) begin
					present <= '0; // copy 1 opens a new round
					lens    <= '0;
				end
			end

			if (payload) begin
				wr_sel[cur_id - 3'd1] <= 1'b1;
				pay_addr              <= pay_addr + 1'b1;
			end

			if (frame_end) begin
				cur_id <= '0;
				if (cur_id != '0) begin
					lens[cur_id - 3'd1]    <= pay_addr;
					present[cur_id - 3'd1] <= 1'b1;
					round_done <= (cur_id == 3'(`COPY_VOTE_N_COPIES)); // last copy closes
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/copy_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "copy_vote_consts.svh"

module copy_buffer (
	input  logic                 clk,
	input  logic                 we,
	input  copy_vote_pkg::addr_t wr_addr,
	input  copy_vote_pkg::byte_t wr_data,
	input  copy_vote_pkg::addr_t rd_addr,
	output copy_vote_pkg::byte_t rd_data
);

	copy_vote_pkg::byte_t mem [2**`COPY_VOTE_ADDR_W];

	// write port a
	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// registered read port b
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: design/pair_compare.sv
`timescale 1ns/100ps
`default_nettype none

`include "copy_vote_consts.svh"

module pair_compare (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     scan_start,
	input  logic                     scan_en,
	input  copy_vote_pkg::addr_t     rd_addr,
	input  copy_vote_pkg::byte_vec_t rd_bytes,
	input  copy_vote_pkg::len_vec_t  lens,
	input  copy_vote_pkg::copy_vec_t present,
	output copy_vote_pkg::copy_id_t  winner
);

	localparam int N = `COPY_VOTE_N_COPIES;

	logic                      scan_en_q; // aligned with rd_bytes
	copy_vote_pkg::addr_t      addr_q;
	copy_vote_pkg::pair_vec_t  byte_mis;  // sticky byte mismatches
	copy_vote_pkg::pair_vec_t  pair_mis;  // with length and presence folded in
	logic [N-1:0][2:0]         agree_cnt;

	// zero based bit of pair (a, b) with a < b
	function automatic int pair_idx(input int a, input int b);
		return a * (2 * N - a - 1) / 2 + (b - a - 1);
	endfunction

	always_ff @(posedge clk) begin
		addr_q <= rd_addr;
	end

	// ==================================================
	// mismatch accumulation
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			scan_en_q <= 1'b0;
			byte_mis  <= '0;
		end else begin
			scan_en_q <= scan_en;
			if (scan_start) begin
				byte_mis <= '0;
			end else if (scan_en_q) begin
				for (int a = 0; a < N; a++) begin
					for (int b = a + 1; b < N; b++) begin
						if (addr_q < lens[a] && addr_q < lens[b] && rd_bytes[a] != rd_bytes[b])
							byte_mis[pair_idx(a, b)] <= 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		for (int a = 0; a < N; a++) begin
			for (int b = a + 1; b < N; b++) begin
				pair_mis[pair_idx(a, b)] = byte_mis[pair_idx(a, b)]
					|| (lens[a] != lens[b]) || !present[a] || !present[b];
			end
		end
	end

	// ==================================================
	// majority pick
	// ==================================================
	always_comb begin
		for (int a = 0; a < N; a++) begin
			agree_cnt[a] = '0;
			for (int b = 0; b < N; b++) begin
				if (b < a && !pair_mis[pair_idx(b, a)])
					agree_cnt[a] += 3'd1;
				else if (b > a && !pair_mis[pair_idx(a, b)])
					agree_cnt[a] += 3'd1;
			end
		end
	end

	// walk down so the lowest qualifying copy wins
	always_comb begin
		winner = '0;
		for (int a = N - 1; a >= 0; a--) begin
			if (present[a] && agree_cnt[a] >= 3'd2)
				winner = 3'(a + 1);
		end
	end

endmodule

`default_nettype wire

// File: design/vote_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "copy_vote_consts.svh"

module vote_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     round_done,
	input  copy_vote_pkg::len_vec_t  lens,
	input  copy_vote_pkg::copy_id_t  winner,
	input  copy_vote_pkg::byte_vec_t rd_bytes,
	output logic                     busy,
	output logic                     scan_start,
	output logic                     scan_en,
	output copy_vote_pkg::addr_t     rd_addr,
	output copy_vote_pkg::byte_t     data_out,
	output logic                     en_out,
	output logic                     lost
);

	copy_vote_pkg::vote_state_t state;
	logic [8:0]                 addr_cnt;  // scan and replay address
	logic [8:0]                 max_len;   // longest copy of the round
	copy_vote_pkg::addr_t       len_max_c;
	copy_vote_pkg::copy_id_t    win_id;
	copy_vote_pkg::addr_t       win_len;

	always_comb begin
		len_max_c = '0;
		for (int c = 0; c < `COPY_VOTE_N_COPIES; c++) begin
			if (lens[c] > len_max_c)
				len_max_c = lens[c];
		end
	end

	assign rd_addr = addr_cnt[7:0];
	assign scan_en = (state == copy_vote_pkg::scan) && (addr_cnt < max_len);
	assign busy    = (state != copy_vote_pkg::idle) || en_out || lost;

	// ==================================================
	// round FSM
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= copy_vote_pkg::idle;
			addr_cnt   <= '0;
			max_len    <= '0;
			win_id     <= '0;
			win_len    <= '0;
			scan_start <= 1'b0;
			en_out     <= 1'b0;
			lost       <= 1'b0;
		end else begin
			scan_start <= 1'b0;
			en_out     <= 1'b0;
			lost       <= 1'b0;
			case (state)
				copy_vote_pkg::idle: begin
					if (round_done) begin
						state      <= copy_vote_pkg::scan;
						addr_cnt   <= '0;
						max_len    <= {1'b0, len_max_c};
						scan_start <= 1'b1; // clears the pair flags
					end
				end
				copy_vote_pkg::scan: begin
					if (addr_cnt == max_len + 9'd1) begin // two cycles of read pipeline
						state    <= copy_vote_pkg::decide;
						addr_cnt <= '0; // byte 0 is read during decide
					end else begin
						addr_cnt <= addr_cnt + 9'd1;
					end
				end
				copy_vote_pkg::decide: begin
					win_id <= winner;
					if (winner == '0) begin
						lost  <= 1'b1;
						state <= copy_vote_pkg::idle;
					end else if (lens[winner - 3'd1] == '0) begin
						state <= copy_vote_pkg::idle; // nothing to replay
					end else begin
						win_len  <= lens[winner - 3'd1];
						addr_cnt <= 9'd1;
						state    <= copy_vote_pkg::replay;
					end
				end
				copy_vote_pkg::replay: begin
					en_out <= 1'b1;
					if (addr_cnt == {1'b0, win_len})
						state <= copy_vote_pkg::idle;
					else
						addr_cnt <= addr_cnt + 9'd1;
				end
				default: state <= copy_vote_pkg::idle;
			endcase
		end
	end

	// output byte trails its address by one read cycle
	always_ff @(posedge clk) begin
		if (state == copy_vote_pkg::replay)
			data_out <= rd_bytes[win_id - 3'd1];
	end

endmodule

`default_nettype wire

// File: design/copy_vote_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "copy_vote_consts.svh"

module copy_vote_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rx_en,
	input  copy_vote_pkg::byte_t rx_data,
	output copy_vote_pkg::byte_t data_out,
	output logic                 en_out,
	output logic                 lost
);

	copy_vote_pkg::copy_vec_t  wr_sel;
	copy_vote_pkg::copy_vec_t  present;
	copy_vote_pkg::addr_t      wr_addr;
	copy_vote_pkg::addr_t      rd_addr;   // shared by all read ports
	copy_vote_pkg::byte_t      wr_data;
	copy_vote_pkg::len_vec_t   lens;
	copy_vote_pkg::byte_vec_t  rd_bytes;
	copy_vote_pkg::copy_id_t   winner;
	logic                      round_done;
	logic                      busy;
	logic                      scan_start;
	logic                      scan_en;

	copy_receiver u_rx (
		.clk        (clk),
		.rst        (rst),
		.rx_en      (rx_en),
		.rx_data    (rx_data),
		.busy       (busy),
		.wr_sel     (wr_sel),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.lens       (lens),
		.present    (present),
		.round_done (round_done)
	);

	// one buffer per copy
	for (genvar g = 0; g < `COPY_VOTE_N_COPIES; g++) begin : g_buf
		copy_buffer u_buf (
			.clk     (clk),
			.we      (wr_sel[g]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.rd_addr (rd_addr),
			.rd_data (rd_bytes[g])
		);
	end

	pair_compare u_cmp (
		.clk        (clk),
		.rst        (rst),
		.scan_start (scan_start),
		.scan_en    (scan_en),
		.rd_addr    (rd_addr),
		.rd_bytes   (rd_bytes),
		.lens       (lens),
		.present    (present),
		.winner     (winner)
	);

	vote_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.round_done (round_done),
		.lens       (lens),
		.winner     (winner),
		.rd_bytes   (rd_bytes),
		.busy       (busy),
		.scan_start (scan_start),
		.scan_en    (scan_en),
		.rd_addr    (rd_addr),
		.data_out   (data_out),
		.en_out     (en_out),
		.lost       (lost)
	);

endmodule

`default_nettype wire

// File: bench/copy_vote_chk.sv
`timescale 1ns/100ps
`default_nettype none

module copy_vote_chk (
	input logic clk,
	input logic rst,
	input logic rx_en,
	input logic en_out,
	input logic lost
);

	int fail_cnt = 0; // failed assertions so far

	// ==================================================
	// output protocol
	// ==================================================
	a_excl: assert property (@(posedge clk) disable iff (rst) !(en_out && lost))
		else begin
			$error("en_out and lost high in the same cycle");
			fail_cnt++;
		end

	a_lost_pulse: assert property (@(posedge clk) disable iff (rst) lost |=> !lost)
		else begin
			$error("lost held for more than one cycle");
			fail_cnt++;
		end

	// replay only runs between rounds
	a_no_overlap: assert property (@(posedge clk) disable iff (rst) !(en_out && rx_en))
		else begin
			$error("en_out high while a frame is arriving");
			fail_cnt++;
		end

	a_reset_quiet: assert property (@(posedge clk) rst |=> (!en_out && !lost))
		else begin
			$error("en_out or lost high during reset");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// File: bench/copy_vote_monitor.sv
`timescale 1ns/100ps
`default_nettype none

`include "copy_vote_consts.svh"

module copy_vote_monitor (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rx_en,
	input  copy_vote_pkg::byte_t rx_data,
	input  copy_vote_pkg::byte_t data_out,
	input  logic                 en_out,
	input  logic                 lost,
	output int                   value_errs,
	output int                   proto_errs,
	output int                   rounds_seen
);

	localparam int N = `COPY_VOTE_N_COPIES;

	copy_vote_pkg::byte_t pay [N][256];    // model of the copy buffers
	int                   plen [N];
	bit                   pres [N];
	copy_vote_pkg::byte_t exp_bytes [256];
	int                   exp_win;         // 0 means a lost pulse is due
	int                   exp_len;
	int                   rounds_closed;
	int                   in_cnt;          // byte index within the frame
	int                   cur;
	int                   nib;
	int                   wa;
	int                   k;
	int                   out_cnt;
	logic                 en_q;

	function automatic bit copies_match(input int a, input int b);
		int i;
		if (plen[a] != plen[b])
			return 1'b0;
		for (i = 0; i < plen[a]; i++) begin
			if (pay[a][i] != pay[b][i])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// lowest present copy agreeing with two or more others
	function automatic int expected_winner();
		int a;
		int b;
		int agree;
		for (a = 0; a < N; a++) begin
			agree = 0;
			for (b = 0; b < N; b++) begin
				if (b != a && pres[a] && pres[b] && copies_match(a, b))
					agree++;
			end
			if (agree >= 2)
				return a + 1;
		end
		return 0;
	endfunction

	// ==================================================
	// round rebuild from the input stream
	// ==================================================
	always @(posedge clk) begin
		if (rst) begin
			in_cnt        = 0;
			cur           = 0;
			wa            = 0;
			rounds_closed = 0;
			for (k = 0; k < N; k++) begin
				pres[k] = 1'b0;
				plen[k] = 0;
			end
		end else if (rx_en) begin
			if (in_cnt == `COPY_VOTE_ID_OFFSET) begin
				nib = int'(rx_data[3:0]);
				cur = (nib >= 1 && nib <= N) ? nib : 0;
				wa  = 0;
				if (nib == 1) begin
					for (k = 0; k < N; k++) begin // copy 1 opens a round
						pres[k] = 1'b0;
						plen[k] = 0;
					end
				end
			end else if (in_cnt > `COPY_VOTE_ID_OFFSET && cur != 0) begin
				pay[cur - 1][wa] = rx_data;
				wa++;
			end
			in_cnt++;
		end else if (in_cnt != 0) begin
			if (cur != 0) begin
				pres[cur - 1] = 1'b1;
				plen[cur - 1] = wa;
				if (cur == N) begin
					exp_win = expected_winner();
					exp_len = (exp_win != 0) ? plen[exp_win - 1] : 0;
					for (k = 0; k < exp_len; k++)
						exp_bytes[k] = pay[exp_win - 1][k];
					rounds_closed++;
				end
			end
			in_cnt = 0;
			cur    = 0;
		end
	end

	// ==================================================
	// output compare
	// ==================================================
	always @(posedge clk) begin
		if (rst) begin
			en_q        = 1'b0;
			out_cnt     = 0;
			value_errs  = 0;
			proto_errs  = 0;
			rounds_seen = 0;
		end else begin
			if (en_out) begin
				if (rounds_closed == rounds_seen || exp_win == 0) begin
					proto_errs++;
					$display("en_out went high at %0t with no replay expected", $time);
				end else if (out_cnt < exp_len && data_out !== exp_bytes[out_cnt]) begin
					value_errs++;
					$display("FAIL %0t: byte %0d of copy %0d is %02h, expected %02h",
						$time, out_cnt, exp_win, data_out, exp_bytes[out_cnt]);
				end
				out_cnt++;
			end
			if (en_q && !en_out) begin
				if (out_cnt != exp_len) begin
					value_errs++;
					$display("FAIL %0t: replay of %0d bytes, expected %0d",
						$time, out_cnt, exp_len);
				end
				out_cnt = 0;
				rounds_seen++;
			end
			if (lost) begin
				if (rounds_closed == rounds_seen) begin
					proto_errs++;
					$display("lost pulsed at %0t with no round closed", $time);
				end else if (exp_win != 0) begin
					value_errs++;
					$display("FAIL %0t: lost pulsed, expected replay of copy %0d",
						$time, exp_win);
				end
				rounds_seen++;
			end
			en_q = en_out;
		end
	end

endmodule

`default_nettype wire

// File: bench/copy_vote_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "copy_vote_consts.svh"

module copy_vote_tb;

	localparam int N_ROUNDS    = 40;
	localparam int CYCLE_LIMIT = N_ROUNDS * (5 * 280 + 600);
	localparam int N           = `COPY_VOTE_N_COPIES;

	logic                 clk;
	logic                 rst;
	logic                 rx_en;
	copy_vote_pkg::byte_t rx_data;
	copy_vote_pkg::byte_t data_out;
	logic                 en_out;
	logic                 lost;
	int                   value_errs;
	int                   proto_errs;
	int                   rounds_seen;
	int                   seed;
	int                   cycles;
	int                   total_errs;
	copy_vote_pkg::byte_t copy_pay [N][256]; // payload of each copy this round
	int                   copy_len [N];
	bit                   copy_on [N];

	copy_vote_top DUT (
		.clk      (clk),
		.rst      (rst),
		.rx_en    (rx_en),
		.rx_data  (rx_data),
		.data_out (data_out),
		.en_out   (en_out),
		.lost     (lost)
	);

	copy_vote_monitor u_mon (
		.clk         (clk),
		.rst         (rst),
		.rx_en       (rx_en),
		.rx_data     (rx_data),
		.data_out    (data_out),
		.en_out      (en_out),
		.lost        (lost),
		.value_errs  (value_errs),
		.proto_errs  (proto_errs),
		.rounds_seen (rounds_seen)
	);

	bind copy_vote_top copy_vote_chk u_chk (
		.clk    (clk),
		.rst    (rst),
		.rx_en  (rx_en),
		.en_out (en_out),
		.lost   (lost)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// stimulus
	// ==================================================
	function automatic logic [3:0] bad_nibble();
		if ($random(seed) & 1)
			return 4'd0;
		return 4'(6 + {$random(seed)} % 10);
	endfunction

	// c < 0 sends a random payload
	task automatic send_frame(input logic [3:0] nib, input int c, input int len);
		int i;
		for (i = 0; i < `COPY_VOTE_ID_OFFSET + 1 + len; i++) begin
			@(posedge clk);
			rx_en <= 1'b1;
			if (i < `COPY_VOTE_ID_OFFSET)
				rx_data <= 8'($random(seed));
			else if (i == `COPY_VOTE_ID_OFFSET)
				rx_data <= {4'($random(seed)), nib}; // upper nibble is noise
			else if (c < 0)
				rx_data <= 8'($random(seed));
			else
				rx_data <= copy_pay[c][i - `COPY_VOTE_ID_OFFSET - 1];
		end
		@(posedge clk);
		rx_en   <= 1'b0;
		rx_data <= '0;
		repeat (2) @(posedge clk); // 3 idle cycles
	endtask

	task automatic wait_round_end();
		logic en_q;
		logic done;
		en_q = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			done = (en_q && !en_out) || lost;
			en_q = en_out;
		end
	endtask

	task automatic run_round(input int r);
		int kind;
		int len;
		int c;
		int i;
		int a;
		int b;
		int idx;
		int clean;
		kind = r % 5;
		if (r == 0)
			len = 1;
		else if (r == 1)
			len = 200;
		else
			len = 1 + {$random(seed)} % 200;
		for (i = 0; i < len; i++)
			copy_pay[0][i] = 8'($random(seed));
		for (c = 0; c < N; c++) begin
			for (i = 0; i < len; i++)
				copy_pay[c][i] = copy_pay[0][i];
			copy_len[c] = len;
			copy_on[c]  = 1'b1;
		end
		idx = (r == 2) ? 0 : {$random(seed)} % len; // first byte differs in round 2
		case (kind)
			1: begin // one or two copies corrupted
				a = {$random(seed)} % N;
				b = (a + 1 + {$random(seed)} % (N - 1)) % N;
				copy_pay[a][idx] ^= 8'($random(seed)) | 8'h01;
				if ($random(seed) & 1) begin
					i = {$random(seed)} % len;
					copy_pay[b][i] ^= 8'h80;
				end
			end
			2: begin // all copies differ pairwise
				clean = {$random(seed)} % (N + 1);
				for (c = 0; c < N; c++) begin
					if (c != clean)
						copy_pay[c][idx] ^= 8'(c + 1);
				end
			end
			3: begin // copies 2 to 4 may be absent and one length is off
				for (c = 1; c < N - 1; c++)
					copy_on[c] = ($random(seed) & 3) != 0;
				a = {$random(seed)} % N;
				if (len < 200) begin
					copy_len[a]      = len + 1;
					copy_pay[a][len] = 8'($random(seed));
				end else begin
					copy_len[a] = len - 1;
				end
			end
			default: ;
		endcase
		for (c = 0; c < N; c++) begin
			if (copy_on[c])
				send_frame(4'(c + 1), c, copy_len[c]);
			if (kind == 4 && (c == 0 || c == 2))
				send_frame(bad_nibble(), -1, 1 + {$random(seed)} % 40); // stray id
		end
		wait_round_end();
	endtask

	// ==================================================
	// run control
	// ==================================================
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a round never finished", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed    = 32'h18d4aabe;
		rst     = 1'b1;
		rx_en   = 1'b0;
		rx_data = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		for (int r = 0; r < N_ROUNDS; r++)
			run_round(r);
		repeat (4) @(posedge clk);
		if (rounds_seen != N_ROUNDS)
			$display("only %0d of %0d rounds gave a result", rounds_seen, N_ROUNDS);
		total_errs = value_errs + proto_errs + DUT.u_chk.fail_cnt
			+ ((rounds_seen != N_ROUNDS) ? 1 : 0);
		$display("errors: value %0d, protocol %0d, assertion %0d, rounds %0d of %0d",
			value_errs, proto_errs, DUT.u_chk.fail_cnt, rounds_seen, N_ROUNDS);
		if (total_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: copy_vote.f
+incdir+design
design/copy_vote_pkg.sv
design/copy_receiver.sv
design/copy_buffer.sv
design/pair_compare.sv
design/vote_ctrl.sv
design/copy_vote_top.sv
bench/copy_vote_chk.sv
bench/copy_vote_monitor.sv
bench/copy_vote_tb.sv

// File: Makefile
# Verilator build, run and lint for the copy vote receiver

VERILATOR ?= verilator
TOP       ?= copy_vote_tb
RTL_TOP   ?= copy_vote_top
FILELIST  ?= copy_vote.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
